//--- bench/issue_stimulus.txt
// Columns (hex): kind_op_wid_rd_a_b_expected. Kind 1 issue after random gap, 4 issue at once,
// 2 drain then check empty, 3 lone load probe (b = expected alm_empty). Op 0 add 1 sub 2 ld 3 st
// ALU results, with 16-bit wrap
1_0_0_01_0005_0003_0008
1_1_1_02_0010_0003_000d
1_0_2_03_ffff_0002_0001
1_1_3_04_0002_0005_fffd
// Store then load of the same address, then an unwritten address
1_3_0_00_0007_abcd_0000
1_2_1_05_0007_0000_abcd
1_2_2_06_0009_0000_0000
2_0_0_00_0000_0000_0000
// ALU ops right behind loads collide on the bus
1_3_3_00_0003_1234_0000
1_2_0_07_0000_0000_0000
4_0_1_08_1111_2222_3333
1_2_2_09_0003_0000_1234
4_1_3_0a_0100_0001_00ff
2_0_0_00_0000_0000_0000
3_2_1_0b_0003_0001_1234
2_0_0_00_0000_0000_0000
1_3_2_00_000f_beef_0000
1_0_0_0c_7fff_0001_8000
1_2_3_0d_000f_0000_beef
4_0_1_0e_0001_0001_0002
1_1_2_0f_0000_0001_ffff
2_0_0_00_0000_0000_0000
3_2_2_10_000f_0001_beef
2_0_0_00_0000_0000_0000

//--- vlog.f
+incdir+src
src/core_types_pkg.sv
src/instr_pkg.sv
src/wb_if.sv
src/alu_pipe.sv
src/mem_unit.sv
src/wb_arbiter.sv
src/pending_tracker.sv
src/issue_top.sv
bench/issue_top_tb.sv

//--- Makefile
# Verilator flow for the issue-to-writeback slice

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module issue_top

sim:
	verilator --binary --timing -f vlog.f --top-module issue_top_tb -Mdir obj_dir
	./obj_dir/Vissue_top_tb > sim.log 2>&1; cat sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/issue_top_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for the issue-to-writeback slice.
// Replays the stimulus file, checks every writeback and the tracker flags.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "core_consts.svh"

module issue_top_tb;

    localparam int MAX_RECORDS = 64;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  issue_valid;
    instr_pkg::op_e        issue_op;
    core_types_pkg::wid_t  issue_wid, alm_empty_wid, wb_wid;
    core_types_pkg::reg_t  issue_rd, wb_rd;
    core_types_pkg::word_t issue_a, issue_b, wb_data;
    logic                  issue_stall, wb_valid, empty, alm_empty;

    // Each record holds kind, op, wid, rd(2), a(4), b(4) and expected data(4) in hex digits
    logic [67:0]           records [MAX_RECORDS];
    int                    record_count;
    int                    cycle_count;
    int unsigned           seed_ret;
    int                    leftover;

    // Issue taken at the last rising edge, with its expected result
    logic                  iss_seen;
    instr_pkg::op_e        iss_op;
    core_types_pkg::wid_t  iss_wid;
    core_types_pkg::reg_t  iss_rd;
    core_types_pkg::word_t iss_exp, cur_exp;
    logic [1:0]            iss_hist;

    // Reference model of outstanding results and per-warp counts
    core_types_pkg::word_t exp_data [`NUM_WARPS][2**`REG_W];
    logic [2**`REG_W-1:0]  exp_live [`NUM_WARPS];
    int                    model_count [`NUM_WARPS];
    int                    store_timer;
    core_types_pkg::wid_t  store_wid_m;
    // Cycles since the last writeback on the bus
    int                    quiet;

    issue_top UUT (.*);

    always #10 clk = ~clk;

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input core_types_pkg::word_t got,
                              input core_types_pkg::word_t expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, expected);
            abort_run();
        end
    endtask

    task automatic check_wid(input string name, input core_types_pkg::wid_t got,
                             input core_types_pkg::wid_t expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, expected);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, expected);
            abort_run();
        end
    endtask

    // Present the instruction, then raise the strobe on the first edge without a stall
    task automatic issue_instr(input logic [67:0] rec);
        issue_valid = 1'b0;
        issue_op    = instr_pkg::op_e'(rec[61:60]);
        issue_wid   = rec[57:56];
        issue_rd    = rec[52:48];
        issue_a     = rec[47:32];
        issue_b     = rec[31:16];
        cur_exp     = rec[15:0];
        @(negedge clk);
        while (issue_stall) @(negedge clk);
        issue_valid = 1'b1;
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic wait_drain();
        do begin
            @(posedge clk);
        end while (quiet < 8);
        @(negedge clk);
        check_bit("empty", empty, 1'b1);
    endtask

    // With a lone load the flag is up four cycles after issue and down four after writeback
    task automatic probe_load(input logic [67:0] rec);
        alm_empty_wid = rec[57:56];
        issue_instr(rec);
        repeat (3) @(negedge clk);
        check_bit("alm_empty", alm_empty, rec[16]);
        while (!wb_valid) @(negedge clk);
        check_wid("wb_wid", wb_wid, rec[57:56]);
        repeat (4) @(negedge clk);
        check_bit("alm_empty", alm_empty, 1'b0);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        iss_seen    <= issue_valid && !reset;
        iss_op      <= issue_op;
        iss_wid     <= issue_wid;
        iss_rd      <= issue_rd;
        iss_exp     <= cur_exp;
        iss_hist    <= {iss_hist[0], issue_valid && !reset};
        if (cycle_count >= 40 * record_count + 100) begin
            $display("Timeout: stimulus did not finish within %0d cycles", cycle_count);
            abort_run();
        end
    end

    // Outputs settle after the rising edge, so the model works on the falling edge
    always @(negedge clk) begin
        if (reset) begin
            for (int w = 0; w < `NUM_WARPS; w++) begin
                exp_live[w]    = '0;
                model_count[w] = 0;
            end
            store_timer = 0;
            quiet       = 0;
        end else begin
            if (store_timer > 0) begin
                store_timer = store_timer - 1;
                if (store_timer == 0) model_count[store_wid_m] -= 1;
            end
            if (iss_seen) begin
                model_count[iss_wid] += 1;
                if (iss_op == instr_pkg::op_store) begin
                    store_timer = `MEM_DELAY;
                    store_wid_m = iss_wid;
                end else if (exp_live[iss_wid][iss_rd]) begin
                    $display("Register %0d of warp %0d issued again while in flight",
                             iss_rd, iss_wid);
                    abort_run();
                end else begin
                    exp_live[iss_wid][iss_rd] = 1'b1;
                    exp_data[iss_wid][iss_rd] = iss_exp;
                end
            end
            if (wb_valid) begin
                if (!exp_live[wb_wid][wb_rd]) begin
                    $display("Writeback to warp %0d register %0d with nothing in flight",
                             wb_wid, wb_rd);
                    abort_run();
                end
                check_word("wb_data", wb_data, exp_data[wb_wid][wb_rd]);
                exp_live[wb_wid][wb_rd] = 1'b0;
                model_count[wb_wid] -= 1;
            end
            if (iss_hist[1]) check_bit("empty", empty, 1'b0);
            quiet = wb_valid ? 0 : quiet + 1;
        end
    end

    initial begin
        reset         = 1'b1;
        issue_valid   = 1'b0;
        issue_op      = instr_pkg::op_add;
        issue_wid     = '0;
        issue_rd      = '0;
        issue_a       = '0;
        issue_b       = '0;
        alm_empty_wid = '0;
        cur_exp       = '0;
        cycle_count   = 0;
        record_count  = 0;
        seed_ret      = $urandom(50);
        for (int i = 0; i < MAX_RECORDS; i++) records[i] = '0;
        $readmemh("bench/issue_stimulus.txt", records);
        while (record_count < MAX_RECORDS && records[record_count][67:64] != 4'h0) begin
            record_count++;
        end

        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_bit("wb_valid", wb_valid, 1'b0);
        check_bit("issue_stall", issue_stall, 1'b0);
        check_bit("alm_empty", alm_empty, 1'b0);
        check_bit("empty", empty, 1'b1);

        for (int i = 0; i < record_count; i++) begin
            case (records[i][67:64])
                4'h1: begin
                    repeat ($urandom % 4) @(negedge clk);
                    issue_instr(records[i]);
                end
                4'h2: wait_drain();
                4'h3: probe_load(records[i]);
                4'h4: issue_instr(records[i]);
                default: begin
                    $display("Unknown record kind in stimulus line %0d", i);
                    abort_run();
                end
            endcase
        end

        leftover = 0;
        for (int w = 0; w < `NUM_WARPS; w++) begin
            if (model_count[w] != 0) begin
                $display("Warp %0d still has %0d instructions in flight after the last record",
                         w, model_count[w]);
                leftover++;
            end
        end
        if (leftover != 0) begin
            abort_run();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

//--- src/issue_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue-to-writeback slice: ALU pipe and memory unit share one
// writeback bus, and a tracker counts each warp's ops in flight.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "core_consts.svh"

module issue_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  instr_pkg::op_e        issue_op,
    input  core_types_pkg::wid_t  issue_wid,
    input  core_types_pkg::reg_t  issue_rd,
    input  core_types_pkg::word_t issue_a,
    input  core_types_pkg::word_t issue_b,
    input  core_types_pkg::wid_t  alm_empty_wid,
    output logic                  issue_stall,
    output logic                  wb_valid,
    output core_types_pkg::wid_t  wb_wid,
    output core_types_pkg::reg_t  wb_rd,
    output core_types_pkg::word_t wb_data,
    output logic                  empty,
    output logic                  alm_empty
);

    logic                       is_alu_op, is_mem_op;
    logic                       alu_busy, mem_busy;
    logic                       store_retire;
    core_types_pkg::wid_t       store_wid;
    logic [1:0]                 decr;
    core_types_pkg::wid_t [1:0] decr_wid;

    wb_if alu_wb ();
    wb_if mem_wb ();

    assign is_alu_op = (issue_op == instr_pkg::op_add) || (issue_op == instr_pkg::op_sub);
    assign is_mem_op = !is_alu_op;

    // Stall only the op kinds whose unit cannot take a new instruction
    assign issue_stall = (is_alu_op && alu_busy) || (is_mem_op && mem_busy);

    alu_pipe alu_pipe_i (
        .clk, .reset,
        .start (issue_valid && is_alu_op),
        .op    (issue_op), .wid (issue_wid), .rd (issue_rd),
        .a     (issue_a),  .b   (issue_b),
        .busy  (alu_busy), .wb  (alu_wb)
    );

    mem_unit mem_unit_i (
        .clk, .reset,
        .start (issue_valid && is_mem_op),
        .op    (issue_op), .wid (issue_wid), .rd (issue_rd),
        .addr  (issue_a[`MEM_ADDR_W-1:0]), .wdata (issue_b),
        .busy  (mem_busy), .store_retire, .store_wid, .wb (mem_wb)
    );

    wb_arbiter wb_arbiter_i (
        .clk, .reset, .alu (alu_wb), .mem (mem_wb),
        .wb_valid, .wb_wid, .wb_rd, .wb_data
    );

    // Lane 0 retires bus writebacks, lane 1 retires stores
    assign decr        = {store_retire, wb_valid};
    assign decr_wid[0] = wb_wid;
    assign decr_wid[1] = store_wid;

    pending_tracker #(.DECR_COUNT (2)) pending_tracker_i (
        .clk, .reset,
        .incr (issue_valid), .incr_wid (issue_wid),
        .decr, .decr_wid, .alm_empty_wid, .empty, .alm_empty
    );

endmodule

//--- src/pending_tracker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-warp count of instructions in flight.
// One increment and DECR_COUNT decrements per cycle, flags lag two cycles.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "core_consts.svh"

module pending_tracker #(
    parameter int DECR_COUNT = 2
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   incr,
    input  core_types_pkg::wid_t                   incr_wid,
    input  logic [DECR_COUNT-1:0]                  decr,
    input  core_types_pkg::wid_t [DECR_COUNT-1:0]  decr_wid,
    input  core_types_pkg::wid_t                   alm_empty_wid,
    output logic                                   empty,
    output logic                                   alm_empty
);

    localparam int COUNT_W = $clog2(DECR_COUNT + 1);

    logic [`NUM_WARPS-1:0]    incr_n, incr_r;
    logic [COUNT_W-1:0]       decr_cnt_n [`NUM_WARPS];
    logic [COUNT_W-1:0]       decr_cnt_r [`NUM_WARPS];
    core_types_pkg::pending_t pending [`NUM_WARPS];
    core_types_pkg::pending_t pending_n [`NUM_WARPS];
    logic [`NUM_WARPS-1:0]    zero_r, alm_r;

    // Sort this cycle's events by warp, counting the decrements of each
    always_comb begin
        for (int w = 0; w < `NUM_WARPS; w++) begin
            incr_n[w]     = incr && (incr_wid == core_types_pkg::wid_t'(w));
            decr_cnt_n[w] = '0;
            for (int i = 0; i < DECR_COUNT; i++) begin
                if (decr[i] && decr_wid[i] == core_types_pkg::wid_t'(w)) begin
                    decr_cnt_n[w] = decr_cnt_n[w] + COUNT_W'(1);
                end
            end
            pending_n[w] = pending[w] + core_types_pkg::pending_t'(incr_r[w])
                         - core_types_pkg::pending_t'(decr_cnt_r[w]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            incr_r <= '0;
            zero_r <= '1;
            alm_r  <= '0;
            for (int w = 0; w < `NUM_WARPS; w++) begin
                decr_cnt_r[w] <= '0;
                pending[w]    <= '0;
            end
        end else begin
            incr_r <= incr_n;
            for (int w = 0; w < `NUM_WARPS; w++) begin
                decr_cnt_r[w] <= decr_cnt_n[w];
                pending[w]    <= pending_n[w];
                zero_r[w]     <= (pending_n[w] == '0);
                alm_r[w]      <= (pending_n[w] == core_types_pkg::pending_t'(`ALM_EMPTY_LEVEL));
            end
        end
    end

    assign empty     = &zero_r;
    assign alm_empty = alm_r[alm_empty_wid];

endmodule

//--- src/wb_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter for the shared writeback bus.
// Grant and bus fields are combinational in the request cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module wb_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    wb_if.arbiter                 alu,
    wb_if.arbiter                 mem,
    output logic                  wb_valid,
    output core_types_pkg::wid_t  wb_wid,
    output core_types_pkg::reg_t  wb_rd,
    output core_types_pkg::word_t wb_data
);

    // High when the memory unit wins the next tie
    logic prio_mem;
    logic alu_win, mem_win;

    assign alu_win = alu.req && (!mem.req || !prio_mem);
    assign mem_win = mem.req && !alu_win;

    assign alu.grant = alu_win;
    assign mem.grant = mem_win;

    // Flip only on a tie so a lone requester keeps the turn order unchanged
    always_ff @(posedge clk) begin
        if (reset) begin
            prio_mem <= 1'b0;
        end else if (alu.req && mem.req) begin
            prio_mem <= !prio_mem;
        end
    end

    assign wb_valid = alu_win || mem_win;
    assign wb_wid   = mem_win ? mem.wid  : alu.wid;
    assign wb_rd    = mem_win ? mem.rd   : alu.rd;
    assign wb_data  = mem_win ? mem.data : alu.data;

endmodule

//--- src/mem_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store unit over a small scratch memory with a fixed access delay.
// Stores retire directly, loads go out through the writeback bus.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "core_consts.svh"

module mem_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  instr_pkg::op_e            op,
    input  core_types_pkg::wid_t      wid,
    input  core_types_pkg::reg_t      rd,
    input  core_types_pkg::mem_addr_t addr,
    input  core_types_pkg::word_t     wdata,
    output logic                      busy,
    output logic                      store_retire,
    output core_types_pkg::wid_t      store_wid,
    wb_if.unit                        wb
);

    localparam int CNT_W = $clog2(`MEM_DELAY + 1);

    instr_pkg::mem_state_e     state;
    logic [CNT_W-1:0]          delay_cnt;
    logic                      last_cycle;
    instr_pkg::op_e            op_r;
    core_types_pkg::wid_t      wid_r;
    core_types_pkg::reg_t      rd_r;
    core_types_pkg::mem_addr_t addr_r;
    core_types_pkg::word_t     wdata_r, rdata_r;
    core_types_pkg::word_t     mem [`MEM_DEPTH];

    assign last_cycle   = (state == instr_pkg::mem_access) && (delay_cnt == CNT_W'(`MEM_DELAY));
    assign store_retire = last_cycle && (op_r == instr_pkg::op_store);
    assign store_wid    = wid_r;
    assign busy         = (state != instr_pkg::mem_idle);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= instr_pkg::mem_idle;
            delay_cnt <= '0;
            for (int i = 0; i < `MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (state)
                instr_pkg::mem_idle: begin
                    if (start) begin
                        state     <= instr_pkg::mem_access;
                        delay_cnt <= CNT_W'(1);
                    end
                end
                instr_pkg::mem_access: begin
                    delay_cnt <= delay_cnt + CNT_W'(1);
                    if (last_cycle) begin
                        if (op_r == instr_pkg::op_store) begin
                            mem[addr_r] <= wdata_r;
                            state       <= instr_pkg::mem_idle;
                        end else begin
                            state <= instr_pkg::mem_hold;
                        end
                    end
                end
                instr_pkg::mem_hold: begin
                    if (wb.grant) state <= instr_pkg::mem_idle;
                end
                default: state <= instr_pkg::mem_idle;
            endcase
        end
    end

    // Request fields and load data
    always_ff @(posedge clk) begin
        if (state == instr_pkg::mem_idle && start) begin
            op_r    <= op;
            wid_r   <= wid;
            rd_r    <= rd;
            addr_r  <= addr;
            wdata_r <= wdata;
        end
        if (last_cycle && op_r == instr_pkg::op_load) begin
            rdata_r <= mem[addr_r];
        end
    end

    assign wb.req  = (state == instr_pkg::mem_hold);
    assign wb.wid  = wid_r;
    assign wb.rd   = rd_r;
    assign wb.data = rdata_r;

endmodule

//--- src/alu_pipe.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-stage add/subtract pipeline feeding the writeback bus.
// A lone op requests the bus two cycles after start.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module alu_pipe (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  instr_pkg::op_e        op,
    input  core_types_pkg::wid_t  wid,
    input  core_types_pkg::reg_t  rd,
    input  core_types_pkg::word_t a,
    input  core_types_pkg::word_t b,
    output logic                  busy,
    wb_if.unit                    wb
);

    logic                  s1_valid, s2_valid;
    instr_pkg::op_e        s1_op;
    core_types_pkg::wid_t  s1_wid, s2_wid;
    core_types_pkg::reg_t  s1_rd, s2_rd;
    core_types_pkg::word_t s1_a, s1_b, s1_result, s2_data;
    logic                  stall;

    // Result waiting in stage two without a grant freezes the whole pipe
    assign stall = s2_valid && !wb.grant;
    assign busy  = stall;

    assign s1_result = (s1_op == instr_pkg::op_sub) ? s1_a - s1_b : s1_a + s1_b;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= start;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (start) begin
                s1_op  <= op;
                s1_wid <= wid;
                s1_rd  <= rd;
                s1_a   <= a;
                s1_b   <= b;
            end
            s2_wid  <= s1_wid;
            s2_rd   <= s1_rd;
            s2_data <= s1_result;
        end
    end

    assign wb.req  = s2_valid;
    assign wb.wid  = s2_wid;
    assign wb.rd   = s2_rd;
    assign wb.data = s2_data;

endmodule

//--- src/wb_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Writeback request from one execution unit to the bus arbiter.
// The unit holds req and its fields until it sees grant.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

interface wb_if;

    logic                  req;
    core_types_pkg::wid_t  wid;
    core_types_pkg::reg_t  rd;
    core_types_pkg::word_t data;
    // One-cycle pulse on the cycle the result goes out on the bus
    logic                  grant;

    modport unit (
        output req, wid, rd, data,
        input  grant
    );

    modport arbiter (
        input  req, wid, rd, data,
        output grant
    );

endinterface

//--- src/instr_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction classes and the memory unit's state encoding.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package instr_pkg;

    // Instruction kind carried on the issue port
    typedef enum logic [1:0] {
        op_add   = 2'd0,
        op_sub   = 2'd1,
        op_load  = 2'd2,
        op_store = 2'd3
    } op_e;

    // Memory unit FSM
    typedef enum logic [1:0] {
        mem_idle   = 2'd0,
        mem_access = 2'd1,
        mem_hold   = 2'd2
    } mem_state_e;

endpackage

//--- src/core_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector types shared by the datapath and the in-flight bookkeeping.
// Widths come from the constants header.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "core_consts.svh"

package core_types_pkg;

    // Warp id
    typedef logic [`WID_W-1:0]      wid_t;

    // Operand and result word
    typedef logic [`WORD_W-1:0]     word_t;

    // Destination register index
    typedef logic [`REG_W-1:0]      reg_t;

    // Number of instructions one warp has in flight
    typedef logic [`PENDING_W-1:0]  pending_t;

    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

endpackage

//--- src/core_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core sizes and timing constants, included wherever a width is needed.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define NUM_WARPS       4
`define WID_W           2
`define WORD_W          16
`define REG_W           5
`define PENDING_W       8
`define ALM_EMPTY_LEVEL 1
`define MEM_DEPTH       16
`define MEM_ADDR_W      4
// Cycles a memory access spends in the access state
`define MEM_DELAY       3

`endif
